/* Bender.yml */
package:
  name: mpmem

sources:
  - hw/mpmem_pkg.sv
  - hw/bank_ram.sv
  - hw/mem_init.sv
  - hw/write_router.sv
  - hw/read_router.sv
  - hw/mpmem_top.sv
  - target: test
    files:
      - test/mpmem_sva.sv
      - test/mpmem_tb.sv

/* build.f */
hw/mpmem_pkg.sv
hw/bank_ram.sv
hw/mem_init.sv
hw/write_router.sv
hw/read_router.sv
hw/mpmem_top.sv
test/mpmem_sva.sv
test/mpmem_tb.sv

/* hw/bank_ram.sv */
`timescale 1ns/100ps

module bank_ram import mpmem_pkg::*; (
  input  logic                clk,
  input  bank_wr_t            wr,
  input  logic                rd_en,
  input  logic [row_bits-1:0] rd_row,
  output data_t               rd_data
);

  data_t mem [num_row];   // storage, cleared by the init sequencer.

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk) begin
    if (wr.wen) begin
      mem[wr.row] <= wr.data;
    end
  end

  // ====================
  // read port
  // ====================
  // the nonblocking update above means a same-cycle read sees the old word.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_row];   // registered, one cycle after enable.
    end
  end

endmodule

/* hw/mem_init.sv */
`timescale 1ns/100ps

module mem_init import mpmem_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  output logic                clr_en,
  output logic [row_bits-1:0] clr_row,
  output logic                ready
);

  localparam logic [row_bits-1:0] last_row = row_bits'(num_row - 1);

  logic last;

  assign last = (clr_row == last_row);   // final row being cleared.

  // ====================
  // row sweep
  // ====================
  // clearing starts straight out of reset with row 0 and ends on the last row.
  // ready rises on the same edge clr_en falls, so the two never overlap.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clr_en  <= 1'b1;
      clr_row <= '0;
      ready   <= 1'b0;
    end else if (clr_en) begin
      clr_row <= clr_row + 1'b1;
      if (last) begin
        clr_en <= 1'b0;
        ready  <= 1'b1;   // held until the next reset.
      end
    end
  end

endmodule

/* hw/mpmem_pkg.sv */
package mpmem_pkg;

  // ====================
  // sizes
  // ====================
  localparam int num_wr    = 2;                      // write ports.
  localparam int num_rd    = 2;                      // read ports.
  localparam int num_bank  = 4;
  localparam int bank_bits = $clog2(num_bank);
  localparam int num_row   = 16;                     // rows per bank.
  localparam int row_bits  = $clog2(num_row);
  localparam int addr_bits = bank_bits + row_bits;   // bank field sits above row field.
  localparam int data_w    = 16;

  // ====================
  // types
  // ====================
  typedef logic [data_w-1:0]    data_t;
  typedef logic [addr_bits-1:0] addr_t;

  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    logic  read;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  rd_vld;
    data_t data;
  } rd_rsp_t;

  // one bank's write command, shared by all of its read-port copies.
  typedef struct packed {
    logic                wen;
    logic [row_bits-1:0] row;
    data_t               data;
  } bank_wr_t;

endpackage

/* hw/mpmem_top.sv */
`timescale 1ns/100ps

module mpmem_top import mpmem_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  wr_req_t wr  [num_wr],
  input  rd_req_t rd  [num_rd],
  output rd_rsp_t rsp [num_rd],
  output logic    ready
);

  logic                clr_en;
  logic [row_bits-1:0] clr_row;

  bank_wr_t            bank_wr      [num_bank];
  logic                bank_rd_en   [num_rd][num_bank];
  logic [row_bits-1:0] bank_rd_row  [num_rd];
  data_t               bank_rd_data [num_rd][num_bank];

  // ====================
  // init and routing
  // ====================
  mem_init u_mem_init (
    .clk     (clk),
    .arst_n  (arst_n),
    .clr_en  (clr_en),
    .clr_row (clr_row),
    .ready   (ready)
  );

  // write ports are held off by clr_en until ready.
  write_router u_write_router (
    .wr      (wr),
    .clr_en  (clr_en),
    .clr_row (clr_row),
    .bank_wr (bank_wr)
  );

  read_router u_read_router (
    .clk          (clk),
    .arst_n       (arst_n),
    .ready        (ready),
    .rd           (rd),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_row  (bank_rd_row),
    .bank_rd_data (bank_rd_data),
    .rsp          (rsp)
  );

  // ====================
  // bank array
  // ====================
  // one copy of each bank per read port, every copy sees the same writes.
  for (genvar p = 0; p < num_rd; p++) begin : g_port
    for (genvar b = 0; b < num_bank; b++) begin : g_bank
      bank_ram u_bank_ram (
        .clk     (clk),
        .wr      (bank_wr[b]),
        .rd_en   (bank_rd_en[p][b]),
        .rd_row  (bank_rd_row[p]),
        .rd_data (bank_rd_data[p][b])
      );
    end
  end

endmodule

/* hw/read_router.sv */
`timescale 1ns/100ps

module read_router import mpmem_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ready,
  input  rd_req_t             rd           [num_rd],
  output logic                bank_rd_en   [num_rd][num_bank],
  output logic [row_bits-1:0] bank_rd_row  [num_rd],
  input  data_t               bank_rd_data [num_rd][num_bank],
  output rd_rsp_t             rsp          [num_rd]
);

  logic [bank_bits-1:0] rd_bank [num_rd];
  logic                 rd_go   [num_rd];
  logic                 vld_q   [num_rd];
  logic [bank_bits-1:0] sel_q   [num_rd];

  // ====================
  // request decode
  // ====================
  always_comb begin
    for (int p = 0; p < num_rd; p++) begin
      rd_bank[p]     = rd[p].addr[addr_bits-1 -: bank_bits];
      bank_rd_row[p] = rd[p].addr[row_bits-1:0];   // row goes to every copy of the port.
      rd_go[p]       = ready && rd[p].read;
      for (int b = 0; b < num_bank; b++) begin
        bank_rd_en[p][b] = rd_go[p] && (rd_bank[p] == bank_bits'(b));   // own copy only.
      end
    end
  end

  // ====================
  // response stage
  // ====================
  // lines up with the one-cycle bank latency.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int p = 0; p < num_rd; p++) begin
        vld_q[p] <= 1'b0;
        sel_q[p] <= '0;
      end
    end else begin
      for (int p = 0; p < num_rd; p++) begin
        vld_q[p] <= rd_go[p];
        sel_q[p] <= rd_bank[p];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < num_rd; p++) begin
      rsp[p].rd_vld = vld_q[p];
      rsp[p].data   = bank_rd_data[p][sel_q[p]];   // pick the bank read last cycle.
    end
  end

endmodule

/* hw/write_router.sv */
`timescale 1ns/100ps

module write_router import mpmem_pkg::*; (
  input  wr_req_t             wr [num_wr],
  input  logic                clr_en,
  input  logic [row_bits-1:0] clr_row,
  output bank_wr_t            bank_wr [num_bank]
);

  logic [bank_bits-1:0] wr_bank [num_wr];
  logic [row_bits-1:0]  wr_row  [num_wr];

  // ====================
  // address split
  // ====================
  always_comb begin
    for (int p = 0; p < num_wr; p++) begin
      wr_bank[p] = wr[p].addr[addr_bits-1 -: bank_bits];   // upper bits pick the bank.
      wr_row[p]  = wr[p].addr[row_bits-1:0];
    end
  end

  // ====================
  // per-bank command
  // ====================
  // clr_en is high for the whole window before ready, so port writes are
  // dropped there and the clear owns every bank.
  always_comb begin
    for (int b = 0; b < num_bank; b++) begin
      bank_wr[b] = '0;

      // walk down so port 0 ends up owning a bank on a conflict.
      for (int p = num_wr - 1; p >= 0; p--) begin
        if (wr[p].write && (wr_bank[p] == bank_bits'(b))) begin
          bank_wr[b].wen  = 1'b1;
          bank_wr[b].row  = wr_row[p];
          bank_wr[b].data = wr[p].data;
        end
      end

      if (clr_en) begin
        bank_wr[b].wen  = 1'b1;
        bank_wr[b].row  = clr_row;
        bank_wr[b].data = '0;   // clear word.
      end
    end
  end

endmodule

/* test/mpmem_cases.txt */
# gap | wr0 we addr data | wr1 we addr data | rd0 re addr | rd1 re addr | exp0 vld data | exp1 vld data
# all hex; gap=1 allows idle cycles before the line, exp is the response to this line's reads.
0 1 03 1111 1 15 2222 0 00 0 00 0 0000 0 0000
1 0 00 0000 0 00 0000 1 03 1 15 1 1111 1 2222
1 0 00 0000 0 00 0000 1 15 1 03 1 2222 1 1111
1 1 2a 3333 1 3f 4444 1 2a 1 3f 1 0000 1 0000
1 0 00 0000 0 00 0000 1 3f 1 2a 1 4444 1 3333
1 0 00 0000 0 00 0000 1 03 1 03 1 1111 1 1111
1 1 07 5555 1 1a 6666 1 15 1 2a 1 2222 1 3333
1 0 00 0000 0 00 0000 1 03 1 07 1 1111 1 5555
1 0 00 0000 0 00 0000 1 1a 1 15 1 6666 1 2222
1 1 03 7777 0 00 0000 1 03 1 03 1 1111 1 1111
1 0 00 0000 0 00 0000 1 03 1 07 1 7777 1 5555
1 1 2a 9999 1 15 8888 1 15 1 2a 1 2222 1 3333
1 0 00 0000 0 00 0000 1 2a 1 15 1 9999 1 8888
1 1 30 a001 0 00 0000 0 00 0 00 0 0000 0 0000
0 1 30 a002 0 00 0000 1 30 0 00 1 a001 0 0000
0 1 30 a003 0 00 0000 1 30 1 30 1 a002 1 a002
0 0 00 0000 0 00 0000 1 30 0 00 1 a003 0 0000
0 0 00 0000 0 00 0000 0 00 0 00 0 0000 0 0000
0 0 00 0000 0 00 0000 0 00 1 30 0 0000 1 a003
1 0 00 0000 0 00 0000 1 3f 1 07 1 4444 1 5555
1 1 2f cafe 1 0f beef 0 00 0 00 0 0000 0 0000
1 0 00 0000 0 00 0000 1 2f 1 0f 1 cafe 1 beef

/* test/mpmem_sva.sv */
`timescale 1ns/100ps

module mpmem_sva import mpmem_pkg::*; (
  input logic    clk,
  input logic    arst_n,
  input logic    ready,
  input wr_req_t wr  [num_wr],
  input rd_req_t rd  [num_rd],
  input rd_rsp_t rsp [num_rd]
);

  int unsigned fail_count = 0;   // read by the testbench at the end.

  // ====================
  // write side
  // ====================
  a_wr_bank: assert property (@(posedge clk) disable iff (!arst_n)
    (ready && wr[0].write && wr[1].write) |->
      (wr[0].addr[addr_bits-1 -: bank_bits] != wr[1].addr[addr_bits-1 -: bank_bits]))
    else begin
      fail_count++;
      $error("both write ports hit the same bank");
    end

  // ====================
  // read side
  // ====================
  for (genvar p = 0; p < num_rd; p++) begin : g_rd
    a_vld_ready: assert property (@(posedge clk) disable iff (!arst_n)
      !ready |-> !rsp[p].rd_vld)
      else begin
        fail_count++;
        $error("rd_vld high on port %0d before ready", p);
      end

    a_vld_cause: assert property (@(posedge clk) disable iff (!arst_n)
      rsp[p].rd_vld |-> $past(ready && rd[p].read))
      else begin
        fail_count++;
        $error("rd_vld on port %0d without a read one cycle earlier", p);
      end

    a_read_vld: assert property (@(posedge clk) disable iff (!arst_n)
      (ready && rd[p].read) |=> rsp[p].rd_vld)
      else begin
        fail_count++;
        $error("read on port %0d got no rd_vld", p);
      end
  end

endmodule

bind mpmem_top mpmem_sva u_sva (
  .clk    (clk),
  .arst_n (arst_n),
  .ready  (ready),
  .wr     (wr),
  .rd     (rd),
  .rsp    (rsp)
);

/* test/mpmem_tb.sv */
`timescale 1ns/100ps

module mpmem_tb import mpmem_pkg::*; ();

  logic    clk;
  logic    arst_n;
  wr_req_t wr  [num_wr];
  rd_req_t rd  [num_rd];
  rd_rsp_t rsp [num_rd];
  logic    ready;

  wr_req_t     nxt_wr  [num_wr];   // values for the next driven cycle.
  rd_req_t     nxt_rd  [num_rd];
  rd_rsp_t     nxt_exp [num_rd];   // response due one cycle after the drive.
  rd_rsp_t     exp_q   [num_rd];
  logic        exp_pend;
  int unsigned lcg_state;

  mpmem_top u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (wr),
    .rd     (rd),
    .rsp    (rsp),
    .ready  (ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================
  // helpers
  // ====================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_rsp(input int port, input rd_rsp_t got, input rd_rsp_t exp);
    if (got.rd_vld !== exp.rd_vld || (exp.rd_vld && got.data !== exp.data)) begin
      abort_run($sformatf("Error at %0t ns: rsp[%0d] got vld=%b data=%h, expected vld=%b data=%h",
                          $time, port, got.rd_vld, got.data, exp.rd_vld, exp.data));
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: ready is %b, expected %b", $time, got, exp));
    end
  endtask

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic clear_next();
    for (int p = 0; p < num_wr; p++) begin
      nxt_wr[p] = '0;
    end
    for (int p = 0; p < num_rd; p++) begin
      nxt_rd[p]  = '0;
      nxt_exp[p] = '0;   // no read, so rd_vld low next cycle.
    end
  endtask

  // drives one cycle and checks the response to the cycle before it.
  task automatic step_cycle();
    @(posedge clk);
    for (int p = 0; p < num_wr; p++) begin
      wr[p] <= nxt_wr[p];
    end
    for (int p = 0; p < num_rd; p++) begin
      rd[p] <= nxt_rd[p];
    end
    @(negedge clk);
    check_ready(ready, 1'b1);
    if (exp_pend) begin
      for (int p = 0; p < num_rd; p++) begin
        check_rsp(p, rsp[p], exp_q[p]);
      end
    end
    for (int p = 0; p < num_rd; p++) begin
      exp_q[p] = nxt_exp[p];
    end
    exp_pend = 1'b1;
  endtask

  // ready must rise after exactly num_row clearing cycles.
  // strobes issued meanwhile hit rows already cleared and must be ignored.
  task automatic wait_for_ready();
    int      n;
    wr_req_t w;
    rd_req_t r;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      for (int p = 0; p < num_wr; p++) begin
        w.write = (n < num_row);
        w.addr  = addr_t'(p * (num_bank - 1) * num_row + n - 1);
        w.data  = '1;
        wr[p]  <= w;
      end
      for (int p = 0; p < num_rd; p++) begin
        r.read = (n < num_row);
        r.addr = addr_t'(p * num_row + n);
        rd[p] <= r;
      end
      @(negedge clk);
      if (n > 4 * num_row) begin
        abort_run("timed out waiting for ready after reset release");
      end
      check_ready(ready, logic'(n >= num_row));
      for (int p = 0; p < num_rd; p++) begin
        check_rsp(p, rsp[p], '0);
      end
    end while (ready !== 1'b1);
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    int    fd;
    int    code;
    int    nf;
    int    idle;
    int    lines_run;
    string line;
    int    f [15];

    arst_n    = 1'b0;
    lcg_state = 32'd11446;
    exp_pend  = 1'b0;
    lines_run = 0;
    for (int p = 0; p < num_wr; p++) begin
      wr[p] = '0;
    end
    for (int p = 0; p < num_rd; p++) begin
      rd[p] = '0;
    end
    clear_next();

    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_ready(ready, 1'b0);
      for (int p = 0; p < num_rd; p++) begin
        check_rsp(p, rsp[p], '0);
      end
    end
    @(posedge clk);
    arst_n <= 1'b1;
    wait_for_ready();

    // every address reads back zero after the clear.
    for (int a = 0; a < num_bank * num_row; a++) begin
      clear_next();
      nxt_rd[0].read        = 1'b1;
      nxt_rd[0].addr        = addr_t'(a);
      nxt_rd[1].read        = 1'b1;
      nxt_rd[1].addr        = addr_t'(num_bank * num_row - 1 - a);
      nxt_exp[0].rd_vld     = 1'b1;
      nxt_exp[1].rd_vld     = 1'b1;
      step_cycle();
    end

    fd = $fopen("test/mpmem_cases.txt", "r");
    if (fd == 0) begin
      abort_run("could not open test/mpmem_cases.txt");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      nf = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                   f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
      if (nf != 15) begin
        abort_run($sformatf("malformed line in the cases file: %s", line));
      end
      if (f[0] != 0) begin
        idle = int'((next_rand() >> 16) % 4);
        repeat (idle) begin
          clear_next();
          step_cycle();
        end
      end
      for (int p = 0; p < num_wr; p++) begin
        nxt_wr[p].write = f[1 + 3 * p][0];
        nxt_wr[p].addr  = addr_t'(f[2 + 3 * p]);
        nxt_wr[p].data  = data_t'(f[3 + 3 * p]);
      end
      for (int p = 0; p < num_rd; p++) begin
        nxt_rd[p].read    = f[7 + 2 * p][0];
        nxt_rd[p].addr    = addr_t'(f[8 + 2 * p]);
        nxt_exp[p].rd_vld = f[11 + 2 * p][0];
        nxt_exp[p].data   = data_t'(f[12 + 2 * p]);
      end
      step_cycle();
      lines_run++;
    end
    $fclose(fd);
    if (lines_run == 0) begin
      abort_run("the cases file held no stimulus lines");
    end

    clear_next();
    step_cycle();   // collects the last response.
    step_cycle();

    if (u_dut.u_sva.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display(">>> FAIL");
      $fatal(1, "assertion failures were reported");
    end
  end

endmodule
